/* rtl/mips_isa_pkg.sv */
package mips_isa_pkg;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_LHU   = 6'h25;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_SLL_F  = 6'h00;
    localparam logic [5:0] FN_SRL_F  = 6'h02;
    localparam logic [5:0] FN_JR_F   = 6'h08;
    localparam logic [5:0] FN_ADDU_F = 6'h21;
    localparam logic [5:0] FN_SUBU_F = 6'h23;
    localparam logic [5:0] FN_AND_F  = 6'h24;
    localparam logic [5:0] FN_OR_F   = 6'h25;
    localparam logic [5:0] FN_XOR_F  = 6'h26;
    localparam logic [5:0] FN_SLT_F  = 6'h2a;

    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10,
        ALUOP_IMM   = 2'b11
    } alu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_fn_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

endpackage

/* rtl/mips_pipe_pkg.sv */
package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // Controls carried from ID into EX
    typedef struct packed {
        logic      valid;
        // EX
        logic      jump;
        logic      jal;
        logic      jr;
        logic      alu_src;
        alu_op_e   alu_op;
        logic      reg_dst;
        // M
        logic      branch;
        logic      nbranch;
        logic      mem_write;
        logic      mem_read;
        mem_size_e st_size;
        // WB
        logic      mem_to_reg;
        logic      reg_write;
        mem_size_e ld_size;
        logic      zero_extend;
        logic      lui;
    } id_ex_ctrl_t;

    // Controls left after EX
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        logic      mem_read;
        mem_size_e st_size;
        mem_size_e ld_size;
        logic      zero_extend;
        logic      redirect;
    } ex_wb_ctrl_t;

endpackage

/* rtl/mips_decode.sv */
`timescale 1ns/1ps

module mips_decode
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
#(
    parameter int NBITS  = 32,
    parameter int RNBITS = 5
) (
    input  logic              i_valid,
    input  logic [NBITS-1:0]  i_instr,
    input  logic [NBITS-1:0]  i_pc4,
    output id_ex_ctrl_t       o_ctrl,
    output logic [NBITS-1:0]  o_ext,
    output logic [NBITS-1:0]  o_pc8,
    output logic [RNBITS-1:0] o_rs,
    output logic [RNBITS-1:0] o_rt,
    output logic [RNBITS-1:0] o_rd
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic        imm_zext;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign imm    = i_instr[15:0];

    assign o_rs = i_instr[25:21];
    assign o_rt = i_instr[20:16];
    assign o_rd = i_instr[15:11];

    // Logical immediates are unsigned
    assign imm_zext = (opcode == OP_ANDI) || (opcode == OP_ORI);
    assign o_ext    = imm_zext ? {{(NBITS-16){1'b0}}, imm} : {{(NBITS-16){imm[15]}}, imm};

    // Link value for jal
    assign o_pc8 = i_pc4 + NBITS'(4);

    always_comb
    begin
        o_ctrl = '0;
        if (i_valid)
        begin
            o_ctrl.valid = 1'b1;
            case (opcode)
                OP_RTYPE:
                begin
                    o_ctrl.alu_op = ALUOP_FUNCT;
                    if (funct == FN_JR_F)
                        o_ctrl.jr = 1'b1;
                    else
                    begin
                        o_ctrl.reg_dst   = 1'b1;
                        o_ctrl.reg_write = 1'b1;
                    end
                end
                OP_ADDIU:
                begin
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                end
                OP_ANDI, OP_ORI, OP_SLTI:
                begin
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.alu_op    = ALUOP_IMM;
                    o_ctrl.reg_write = 1'b1;
                end
                OP_LUI:
                begin
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.lui       = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                end
                OP_LW, OP_LBU, OP_LHU:
                begin
                    o_ctrl.alu_src    = 1'b1;
                    o_ctrl.mem_read   = 1'b1;
                    o_ctrl.mem_to_reg = 1'b1;
                    o_ctrl.reg_write  = 1'b1;
                    o_ctrl.ld_size    = (opcode == OP_LW)  ? SIZE_WORD :
                                        (opcode == OP_LHU) ? SIZE_HALF : SIZE_BYTE;
                    // Narrow loads fill the upper bits with zeros
                    o_ctrl.zero_extend = (opcode != OP_LW);
                end
                OP_SW, OP_SB:
                begin
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.st_size   = (opcode == OP_SW) ? SIZE_WORD : SIZE_BYTE;
                end
                OP_BEQ:
                begin
                    o_ctrl.alu_op = ALUOP_SUB;
                    o_ctrl.branch = 1'b1;
                end
                OP_BNE:
                begin
                    o_ctrl.alu_op  = ALUOP_SUB;
                    o_ctrl.nbranch = 1'b1;
                end
                OP_J:
                    o_ctrl.jump = 1'b1;
                OP_JAL:
                begin
                    o_ctrl.jump      = 1'b1;
                    o_ctrl.jal       = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                end
                default:
                    ;
            endcase
        end
    end

endmodule

/* rtl/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile #(
    parameter int NBITS  = 32,
    parameter int RNBITS = 5
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [RNBITS-1:0] i_ra1,
    input  logic [RNBITS-1:0] i_ra2,
    input  logic              i_we,
    input  logic [RNBITS-1:0] i_wa,
    input  logic [NBITS-1:0]  i_wd,
    output logic [NBITS-1:0]  o_rd1,
    output logic [NBITS-1:0]  o_rd2
);

    logic [NBITS-1:0] regs [2**RNBITS];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 2**RNBITS; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_wa != '0))
            regs[i_wa] <= i_wd;
    end

    // r0 reads zero and a pending write is forwarded
    assign o_rd1 = (i_ra1 == '0)                ? '0   :
                   (i_we && (i_wa == i_ra1))    ? i_wd : regs[i_ra1];

    assign o_rd2 = (i_ra2 == '0)                ? '0   :
                   (i_we && (i_wa == i_ra2))    ? i_wd : regs[i_ra2];

endmodule

/* rtl/mips_stage_reg.sv */
`timescale 1ns/1ps

module mips_stage_reg #(
    parameter type ctrl_t = logic,
    parameter int  DW     = 32
) (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  ctrl_t         i_ctrl,
    input  logic [DW-1:0] i_data,
    output ctrl_t         o_ctrl,
    output logic [DW-1:0] o_data
);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_ctrl <= '0;
        else
            o_ctrl <= i_ctrl;
    end

    always_ff @(posedge i_clk)
    begin
        o_data <= i_data;
    end

endmodule

/* rtl/mips_alu_exec.sv */
`timescale 1ns/1ps

module mips_alu_exec
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
#(
    parameter int NBITS  = 32,
    parameter int RNBITS = 5
) (
    input  id_ex_ctrl_t       i_ctrl,
    input  logic [NBITS-1:0]  i_pc4,
    input  logic [NBITS-1:0]  i_pc8,
    input  logic [NBITS-1:0]  i_instr,
    input  logic [NBITS-1:0]  i_rs_val,
    input  logic [NBITS-1:0]  i_rt_val,
    input  logic [NBITS-1:0]  i_ext,
    input  logic [RNBITS-1:0] i_rt,
    input  logic [RNBITS-1:0] i_rd,
    output ex_wb_ctrl_t       o_ctrl,
    output logic [NBITS-1:0]  o_result,
    output logic [RNBITS-1:0] o_dest,
    output logic [NBITS-1:0]  o_store_data,
    output logic [NBITS-1:0]  o_target
);

    alu_fn_e          alu_fn;
    logic [NBITS-1:0] op_b;
    logic [NBITS-1:0] alu_res;
    logic [4:0]       shamt;
    logic             zero;
    logic             take_branch;
    logic [NBITS-1:0] branch_target;
    logic [NBITS-1:0] jump_target;

    assign shamt = i_instr[10:6];

    always_comb
    begin
        case (i_ctrl.alu_op)
            ALUOP_ADD:
                alu_fn = ALU_ADD;
            ALUOP_SUB:
                alu_fn = ALU_SUB;
            ALUOP_FUNCT:
                case (i_instr[5:0])
                    FN_SUBU_F: alu_fn = ALU_SUB;
                    FN_AND_F:  alu_fn = ALU_AND;
                    FN_OR_F:   alu_fn = ALU_OR;
                    FN_XOR_F:  alu_fn = ALU_XOR;
                    FN_SLT_F:  alu_fn = ALU_SLT;
                    FN_SLL_F:  alu_fn = ALU_SLL;
                    FN_SRL_F:  alu_fn = ALU_SRL;
                    default:   alu_fn = ALU_ADD;
                endcase
            default:
                case (i_instr[31:26])
                    OP_ANDI: alu_fn = ALU_AND;
                    OP_ORI:  alu_fn = ALU_OR;
                    default: alu_fn = ALU_SLT;
                endcase
        endcase
    end

    assign op_b = i_ctrl.alu_src ? i_ext : i_rt_val;

    always_comb
    begin
        case (alu_fn)
            ALU_SUB: alu_res = i_rs_val - op_b;
            ALU_AND: alu_res = i_rs_val & op_b;
            ALU_OR:  alu_res = i_rs_val | op_b;
            ALU_XOR: alu_res = i_rs_val ^ op_b;
            ALU_SLT: alu_res = {{(NBITS-1){1'b0}}, $signed(i_rs_val) < $signed(op_b)};
            ALU_SLL: alu_res = op_b << shamt;
            ALU_SRL: alu_res = op_b >> shamt;
            default: alu_res = i_rs_val + op_b;
        endcase
    end

    assign zero = (alu_res == '0);

    assign o_result = i_ctrl.jal ? i_pc8 :
                      i_ctrl.lui ? {i_ext[15:0], {(NBITS-16){1'b0}}} : alu_res;

    assign o_dest = i_ctrl.jal     ? {RNBITS{1'b1}} :
                    i_ctrl.reg_dst ? i_rd           : i_rt;

    assign o_store_data = i_rt_val;

    // Targets
    assign take_branch   = (i_ctrl.branch && zero) || (i_ctrl.nbranch && !zero);
    assign branch_target = i_pc4 + (i_ext << 2);
    assign jump_target   = {i_pc4[NBITS-1:28], i_instr[25:0], 2'b00};

    assign o_target = i_ctrl.jr   ? i_rs_val    :
                      i_ctrl.jump ? jump_target : branch_target;

    always_comb
    begin
        o_ctrl             = '0;
        o_ctrl.valid       = i_ctrl.valid;
        o_ctrl.reg_write   = i_ctrl.reg_write;
        o_ctrl.mem_to_reg  = i_ctrl.mem_to_reg;
        o_ctrl.mem_write   = i_ctrl.mem_write;
        o_ctrl.mem_read    = i_ctrl.mem_read;
        o_ctrl.st_size     = i_ctrl.st_size;
        o_ctrl.ld_size     = i_ctrl.ld_size;
        o_ctrl.zero_extend = i_ctrl.zero_extend;
        o_ctrl.redirect    = i_ctrl.valid && (take_branch || i_ctrl.jump || i_ctrl.jr);
    end

endmodule

/* rtl/mips_id_ex_top.sv */
`timescale 1ns/1ps

module mips_id_ex_top
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
#(
    parameter int NBITS  = 32,
    parameter int RNBITS = 5
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  logic [NBITS-1:0]  i_instr,
    input  logic [NBITS-1:0]  i_pc4,
    output logic              o_wb_valid,
    output logic              o_wb_we,
    output logic [RNBITS-1:0] o_wb_rd,
    output logic [NBITS-1:0]  o_wb_data,
    output logic              o_mem_we,
    output logic              o_mem_re,
    output mem_size_e         o_mem_size,
    output logic [NBITS-1:0]  o_mem_wdata,
    output mem_size_e         o_ld_size,
    output logic              o_ld_zext,
    output logic              o_redirect,
    output logic [NBITS-1:0]  o_redirect_pc
);

    localparam int ID_EX_DW = 6*NBITS + 2*RNBITS;
    localparam int EX_WB_DW = 3*NBITS + RNBITS;

    // ID
    id_ex_ctrl_t       id_ctrl;
    logic [NBITS-1:0]  id_ext;
    logic [NBITS-1:0]  id_pc8;
    logic [RNBITS-1:0] id_rs;
    logic [RNBITS-1:0] id_rt;
    logic [RNBITS-1:0] id_rd;
    logic [NBITS-1:0]  id_rs_val;
    logic [NBITS-1:0]  id_rt_val;

    // EX
    id_ex_ctrl_t       ex_ctrl;
    logic [NBITS-1:0]  ex_pc4;
    logic [NBITS-1:0]  ex_pc8;
    logic [NBITS-1:0]  ex_instr;
    logic [NBITS-1:0]  ex_rs_val;
    logic [NBITS-1:0]  ex_rt_val;
    logic [NBITS-1:0]  ex_ext;
    logic [RNBITS-1:0] ex_rt;
    logic [RNBITS-1:0] ex_rd;
    ex_wb_ctrl_t       ex_out_ctrl;
    logic [NBITS-1:0]  ex_result;
    logic [RNBITS-1:0] ex_dest;
    logic [NBITS-1:0]  ex_store_data;
    logic [NBITS-1:0]  ex_target;

    // WB
    ex_wb_ctrl_t       wb_ctrl;
    logic [NBITS-1:0]  wb_result;
    logic [RNBITS-1:0] wb_dest;
    logic [NBITS-1:0]  wb_store_data;
    logic [NBITS-1:0]  wb_target;
    logic              wb_we;

    logic [ID_EX_DW-1:0] id_ex_din;
    logic [ID_EX_DW-1:0] id_ex_dout;
    logic [EX_WB_DW-1:0] ex_wb_din;
    logic [EX_WB_DW-1:0] ex_wb_dout;

    mips_decode #(
        .NBITS  (NBITS),
        .RNBITS (RNBITS)
    ) decode_i (
        .i_valid (i_valid),
        .i_instr (i_instr),
        .i_pc4   (i_pc4),
        .o_ctrl  (id_ctrl),
        .o_ext   (id_ext),
        .o_pc8   (id_pc8),
        .o_rs    (id_rs),
        .o_rt    (id_rt),
        .o_rd    (id_rd)
    );

    mips_regfile #(
        .NBITS  (NBITS),
        .RNBITS (RNBITS)
    ) regfile_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ra1   (id_rs),
        .i_ra2   (id_rt),
        .i_we    (wb_we),
        .i_wa    (wb_dest),
        .i_wd    (wb_result),
        .o_rd1   (id_rs_val),
        .o_rd2   (id_rt_val)
    );

    assign id_ex_din = {i_pc4, id_pc8, i_instr, id_rs_val, id_rt_val, id_ext, id_rt, id_rd};

    mips_stage_reg #(
        .ctrl_t (id_ex_ctrl_t),
        .DW     (ID_EX_DW)
    ) id_ex_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (id_ctrl),
        .i_data  (id_ex_din),
        .o_ctrl  (ex_ctrl),
        .o_data  (id_ex_dout)
    );

    assign {ex_pc4, ex_pc8, ex_instr, ex_rs_val, ex_rt_val, ex_ext, ex_rt, ex_rd} = id_ex_dout;

    mips_alu_exec #(
        .NBITS  (NBITS),
        .RNBITS (RNBITS)
    ) alu_exec_i (
        .i_ctrl       (ex_ctrl),
        .i_pc4        (ex_pc4),
        .i_pc8        (ex_pc8),
        .i_instr      (ex_instr),
        .i_rs_val     (ex_rs_val),
        .i_rt_val     (ex_rt_val),
        .i_ext        (ex_ext),
        .i_rt         (ex_rt),
        .i_rd         (ex_rd),
        .o_ctrl       (ex_out_ctrl),
        .o_result     (ex_result),
        .o_dest       (ex_dest),
        .o_store_data (ex_store_data),
        .o_target     (ex_target)
    );

    assign ex_wb_din = {ex_result, ex_dest, ex_store_data, ex_target};

    mips_stage_reg #(
        .ctrl_t (ex_wb_ctrl_t),
        .DW     (EX_WB_DW)
    ) ex_wb_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (ex_out_ctrl),
        .i_data  (ex_wb_din),
        .o_ctrl  (wb_ctrl),
        .o_data  (ex_wb_dout)
    );

    assign {wb_result, wb_dest, wb_store_data, wb_target} = ex_wb_dout;

    // Loads write back from memory, outside this slice
    assign wb_we = wb_ctrl.valid & wb_ctrl.reg_write & ~wb_ctrl.mem_to_reg;

    assign o_wb_valid    = wb_ctrl.valid;
    assign o_wb_we       = wb_we;
    assign o_wb_rd       = wb_dest;
    assign o_wb_data     = wb_result;
    assign o_mem_we      = wb_ctrl.mem_write;
    assign o_mem_re      = wb_ctrl.mem_read;
    assign o_mem_size    = wb_ctrl.st_size;
    assign o_mem_wdata   = wb_store_data;
    assign o_ld_size     = wb_ctrl.ld_size;
    assign o_ld_zext     = wb_ctrl.zero_extend;
    assign o_redirect    = wb_ctrl.redirect;
    assign o_redirect_pc = wb_target;

endmodule

/* bench/mips_id_ex_props.sv */
`timescale 1ns/1ps

module mips_id_ex_props (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_valid,
    input logic i_wb_valid,
    input logic i_wb_we,
    input logic i_mem_we,
    input logic i_redirect
);

    int fail_count = 0;

    // Both stage bundles clear on a reset edge
    reset_clears_a: assert property (@(posedge i_clk)
        !i_rst_n |=> (!i_wb_valid && !i_wb_we && !i_mem_we && !i_redirect))
    else
    begin
        fail_count++;
        $error("control outputs active after a reset cycle");
    end

    active_needs_valid_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_we || i_mem_we || i_redirect) |-> i_wb_valid)
    else
    begin
        fail_count++;
        $error("write or redirect without o_wb_valid");
    end

    valid_latency_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> ##2 i_wb_valid)
    else
    begin
        fail_count++;
        $error("o_wb_valid missing two cycles after a valid slot");
    end

    // Stays low until a valid slot arrives
    idle_latency_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_valid |-> ##2 !i_wb_valid)
    else
    begin
        fail_count++;
        $error("o_wb_valid high two cycles after an invalid slot");
    end

endmodule

/* bench/mips_id_ex_tb.sv */
`timescale 1ns/1ps

module mips_id_ex_tb;

    localparam int NBITS         = 32;
    localparam int RNBITS        = 5;
    localparam int NCOL          = 15;
    localparam int MAXV          = 64;
    localparam int RESET_CYCLES  = 10;
    localparam int DRAIN_TIMEOUT = 20;

    // Pattern columns
    localparam int C_TEST  = 0;
    localparam int C_VALID = 1;
    localparam int C_INSTR = 2;
    localparam int C_PC4   = 3;
    localparam int C_WE    = 4;
    localparam int C_RD    = 5;
    localparam int C_DATA  = 6;
    localparam int C_MWE   = 7;
    localparam int C_MRE   = 8;
    localparam int C_MSZ   = 9;
    localparam int C_WDATA = 10;
    localparam int C_LSZ   = 11;
    localparam int C_LZX   = 12;
    localparam int C_RED   = 13;
    localparam int C_RPC   = 14;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_valid;
    logic [NBITS-1:0]  i_instr;
    logic [NBITS-1:0]  i_pc4;
    logic              o_wb_valid;
    logic              o_wb_we;
    logic [RNBITS-1:0] o_wb_rd;
    logic [NBITS-1:0]  o_wb_data;
    logic              o_mem_we;
    logic              o_mem_re;
    logic [1:0]        o_mem_size;
    logic [NBITS-1:0]  o_mem_wdata;
    logic [1:0]        o_ld_size;
    logic              o_ld_zext;
    logic              o_redirect;
    logic [NBITS-1:0]  o_redirect_pc;

    logic [31:0] pat [NCOL*MAXV];
    int          nvec;
    int          errors;
    int          test_errors;
    int          test_vecs;
    int          tests_run;
    int          checked;
    int          seed;
    int          wait_cnt;

    mips_id_ex_top #(
        .NBITS  (NBITS),
        .RNBITS (RNBITS)
    ) dut_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc4         (i_pc4),
        .o_wb_valid    (o_wb_valid),
        .o_wb_we       (o_wb_we),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_mem_we      (o_mem_we),
        .o_mem_re      (o_mem_re),
        .o_mem_size    (o_mem_size),
        .o_mem_wdata   (o_mem_wdata),
        .o_ld_size     (o_ld_size),
        .o_ld_zext     (o_ld_zext),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    bind mips_id_ex_top mips_id_ex_props props_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_wb_valid (o_wb_valid),
        .i_wb_we    (o_wb_we),
        .i_mem_we   (o_mem_we),
        .i_redirect (o_redirect)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
            #2 i_clk = ~i_clk;
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset and r0";
            2:       return "R-type and write-through";
            3:       return "I-type immediates";
            4:       return "loads and stores";
            5:       return "branches and jumps";
            6:       return "invalid slots";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int v);
        assert (got === exp)
        else
        begin
            $display("MISMATCH vector %0d %s: got 0x%08h, expected 0x%08h", v, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d %s: %0d vectors, %0d errors", id, test_name(id), test_vecs,
                 test_errors);
        tests_run++;
        test_vecs   = 0;
        test_errors = 0;
    endtask

    task automatic check_slot(input int v);
        int b;
        b = v * NCOL;
        check_field("o_wb_valid", 32'(o_wb_valid), 32'(pat[b + C_VALID][0]), v);
        check_field("o_wb_we", 32'(o_wb_we), pat[b + C_WE], v);
        check_field("o_mem_we", 32'(o_mem_we), pat[b + C_MWE], v);
        check_field("o_mem_re", 32'(o_mem_re), pat[b + C_MRE], v);
        check_field("o_redirect", 32'(o_redirect), pat[b + C_RED], v);
        if (pat[b + C_WE] != 0)
        begin
            check_field("o_wb_rd", 32'(o_wb_rd), pat[b + C_RD], v);
            check_field("o_wb_data", o_wb_data, pat[b + C_DATA], v);
        end
        // Memory address rides on the result word
        if (pat[b + C_MWE] != 0 || pat[b + C_MRE] != 0)
            check_field("o_wb_data", o_wb_data, pat[b + C_DATA], v);
        if (pat[b + C_MWE] != 0)
        begin
            check_field("o_mem_size", 32'(o_mem_size), pat[b + C_MSZ], v);
            check_field("o_mem_wdata", o_mem_wdata, pat[b + C_WDATA], v);
        end
        if (pat[b + C_MRE] != 0)
        begin
            check_field("o_ld_size", 32'(o_ld_size), pat[b + C_LSZ], v);
            check_field("o_ld_zext", 32'(o_ld_zext), pat[b + C_LZX], v);
        end
        if (pat[b + C_RED] != 0)
            check_field("o_redirect_pc", o_redirect_pc, pat[b + C_RPC], v);
        checked++;
        test_vecs++;
        if (v == nvec - 1 || pat[b + NCOL + C_TEST] != pat[b + C_TEST])
            report_test(pat[b + C_TEST]);
    endtask

    task automatic drive_slot(input int v);
        int b;
        b = v * NCOL;
        i_valid = pat[b + C_VALID][0];
        i_instr = pat[b + C_INSTR];
        i_pc4   = pat[b + C_PC4];
    endtask

    // Idle slots carry junk payload
    task automatic drive_idle();
        i_valid = 1'b0;
        i_instr = $random(seed);
        i_pc4   = $random(seed);
    endtask

    initial
    begin
        i_rst_n     = 1'b0;
        i_valid     = 1'b0;
        i_instr     = '0;
        i_pc4       = '0;
        seed        = 32'hcd9b_b2c5;
        errors      = 0;
        test_errors = 0;
        test_vecs   = 0;
        tests_run   = 0;
        checked     = 0;

        $readmemh("bench/mips_id_ex_patterns.txt", pat);
        nvec = 0;
        while (nvec < MAXV && pat[nvec*NCOL + C_TEST] != 32'hff
               && pat[nvec*NCOL + C_TEST] != 32'h0)
            nvec++;
        if (nvec == 0 || nvec == MAXV)
        begin
            $display("pattern file holds no vectors or lacks its end marker");
            errors++;
        end

        for (int i = 0; i < RESET_CYCLES; i++)
            @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        // Bundles cleared by reset
        check_field("o_wb_valid (reset)", 32'(o_wb_valid), 32'h0, -1);
        check_field("o_wb_we (reset)", 32'(o_wb_we), 32'h0, -1);
        check_field("o_mem_we (reset)", 32'(o_mem_we), 32'h0, -1);
        check_field("o_mem_re (reset)", 32'(o_mem_re), 32'h0, -1);
        check_field("o_redirect (reset)", 32'(o_redirect), 32'h0, -1);

        if (nvec > 0 && nvec < MAXV)
        begin
            for (int c = 0; c < nvec + 2; c++)
            begin
                @(posedge i_clk);
                #1;
                if (c >= 2)
                    check_slot(c - 2);
                if (c < nvec)
                    drive_slot(c);
                else
                    drive_idle();
            end
        end

        wait_cnt = 0;
        while (o_wb_valid && wait_cnt < DRAIN_TIMEOUT)
        begin
            @(posedge i_clk);
            #1;
            wait_cnt++;
        end
        if (o_wb_valid)
        begin
            $display("timeout: o_wb_valid still high %0d cycles after the last slot",
                     DRAIN_TIMEOUT);
            errors++;
        end

        if (dut_i.props_i.fail_count != 0)
        begin
            $display("%0d bound property failures", dut_i.props_i.fail_count);
            errors += dut_i.props_i.fail_count;
        end

        $display("tests %0d, vectors checked %0d, errors %0d", tests_run, checked, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* bench/mips_id_ex_patterns.txt */
// test valid instr pc4 | wb_we wb_rd wb_data | mem_we mem_re mem_size mem_wdata
// ld_size ld_zext | redirect redirect_pc ; test ff ends the stream
// test 1: r0 stays zero
1 1 24000005 00400004 1 00 00000005 0 0 0 00000000 0 0 0 00000000
1 1 24010123 00400008 1 01 00000123 0 0 0 00000000 0 0 0 00000000
1 1 00001821 0040000c 1 03 00000000 0 0 0 00000000 0 0 0 00000000
// test 2: R-type, producers two slots ahead
2 1 2402fff0 00400010 1 02 fffffff0 0 0 0 00000000 0 0 0 00000000
2 1 240400f0 00400014 1 04 000000f0 0 0 0 00000000 0 0 0 00000000
2 1 00222821 00400018 1 05 00000113 0 0 0 00000000 0 0 0 00000000
2 1 00813023 0040001c 1 06 ffffffcd 0 0 0 00000000 0 0 0 00000000
2 1 00443824 00400020 1 07 000000f0 0 0 0 00000000 0 0 0 00000000
2 1 00244025 00400024 1 08 000001f3 0 0 0 00000000 0 0 0 00000000
2 1 00a14826 00400028 1 09 00000030 0 0 0 00000000 0 0 0 00000000
2 1 0041502a 0040002c 1 0a 00000001 0 0 0 00000000 0 0 0 00000000
2 1 0022582a 00400030 1 0b 00000000 0 0 0 00000000 0 0 0 00000000
2 1 00016100 00400034 1 0c 00001230 0 0 0 00000000 0 0 0 00000000
2 1 00066a02 00400038 1 0d 00ffffff 0 0 0 00000000 0 0 0 00000000
// test 3: addiu, slti, andi, ori, lui
3 1 242e8000 0040003c 1 0e ffff8123 0 0 0 00000000 0 0 0 00000000
3 1 282fffff 00400040 1 0f 00000000 0 0 0 00000000 0 0 0 00000000
3 1 2850fff8 00400044 1 10 00000001 0 0 0 00000000 0 0 0 00000000
3 1 3051ff0f 00400048 1 11 0000ff00 0 0 0 00000000 0 0 0 00000000
3 1 34128001 0040004c 1 12 00008001 0 0 0 00000000 0 0 0 00000000
3 1 3c13abcd 00400050 1 13 abcd0000 0 0 0 00000000 0 0 0 00000000
// test 4: sw, sb, lw, lbu, lhu
4 1 ac810010 00400054 0 00 00000100 1 0 2 00000123 0 0 0 00000000
4 1 a093fffc 00400058 0 00 000000ec 1 0 0 abcd0000 0 0 0 00000000
4 1 8c340004 0040005c 0 00 00000127 0 1 0 00000000 2 0 0 00000000
4 1 9035ffff 00400060 0 00 00000122 0 1 0 00000000 0 1 0 00000000
4 1 94960002 00400064 0 00 000000f2 0 1 0 00000000 1 1 0 00000000
// test 5: beq, bne, j, jal, jr
5 1 10250004 00400068 0 00 00000000 0 0 0 00000000 0 0 0 00000000
5 1 11600008 0040006c 0 00 00000000 0 0 0 00000000 0 0 1 0040008c
5 1 1425fffc 00400070 0 00 00000000 0 0 0 00000000 0 0 1 00400060
5 1 14e40010 00400074 0 00 00000000 0 0 0 00000000 0 0 0 00000000
5 1 08100040 00400078 0 00 00000000 0 0 0 00000000 0 0 1 00400100
5 1 0c100080 0040007c 1 1f 00400080 0 0 0 00000000 0 0 1 00400200
5 1 01800008 00400080 0 00 00000000 0 0 0 00000000 0 0 1 00001230
5 1 03e00008 00400084 0 00 00000000 0 0 0 00000000 0 0 1 00400080
// test 6: invalid slots leave no trace
6 0 24017777 00400088 0 00 00000000 0 0 0 00000000 0 0 0 00000000
6 1 0020b821 0040008c 1 17 00000123 0 0 0 00000000 0 0 0 00000000
6 0 0c100080 00400090 0 00 00000000 0 0 0 00000000 0 0 0 00000000
6 0 ac810010 00400094 0 00 00000000 0 0 0 00000000 0 0 0 00000000
6 1 03e0c021 00400098 1 18 00400080 0 0 0 00000000 0 0 0 00000000
ff 0 00000000 00000000 0 00 00000000 0 0 0 00000000 0 0 0 00000000

/* src.f */
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/mips_decode.sv
rtl/mips_regfile.sv
rtl/mips_stage_reg.sv
rtl/mips_alu_exec.sv
rtl/mips_id_ex_top.sv
bench/mips_id_ex_props.sv
bench/mips_id_ex_tb.sv

/* Makefile */
TOP = mips_id_ex_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
